//--- sim/branch_resolve_stim.txt
// kind op pred pc offset rs1 rs2 taken mispredict illegal redirect  (kind 0 branch)
// kind 1 is a lookup: pc in the pc column, expected prediction in the taken column, f ends
0 0 0 00000100 00000040 00000005 00000005 1 1 0 00000140
0 0 1 00000104 00000020 00000005 00000006 0 1 0 00000108
0 1 1 00000108 ffffffe0 00000005 00000006 1 0 0 000000e8
0 1 0 0000010c 00000010 00000007 00000007 0 0 0 00000110
0 2 1 00000110 00000008 80000000 00000001 1 0 0 00000118
0 2 0 00000114 00000008 00000001 80000000 0 0 0 00000118
0 3 0 00000118 00000100 ffffffff 00000000 0 0 0 0000011c
0 3 0 0000011c 00000100 00000000 ffffffff 1 1 0 0000021c
0 4 0 00000120 0000000c 80000000 00000001 0 0 0 00000124
0 4 0 00000124 0000000c 00000001 80000000 1 1 0 00000130
0 5 1 00000128 00000030 ffffffff 00000000 1 0 0 00000158
0 5 1 0000012c 00000030 00000000 00000001 0 1 0 00000130
0 6 1 00000130 00000040 00000001 00000001 0 0 1 00000134
0 7 0 00000134 00000040 00000000 00000000 0 0 1 00000138
0 0 0 00000100 00000040 00000005 00000005 1 1 0 00000140
0 0 1 00000100 00000040 00000005 00000005 1 0 0 00000140
0 1 1 00000140 00000008 00000003 00000003 0 1 0 00000144
0 1 0 00000104 00000008 00000003 00000003 0 0 0 00000108
0 3 1 00000110 00000008 00000002 00000002 1 0 0 00000118
0 4 1 00000124 0000000c 00000000 00000000 0 1 0 00000128
0 4 1 00000124 0000000c 00000000 00000000 0 1 0 00000128
0 0 1 00000130 00000040 00000009 00000009 1 0 0 00000170
0 0 0 00000134 00000040 00000009 00000008 0 0 0 00000138
1 0 0 00000100 00000000 00000000 00000000 1 0 0 00000000
1 0 0 00000140 00000000 00000000 00000000 1 0 0 00000000
1 0 0 00000104 00000000 00000000 00000000 0 0 0 00000000
1 0 0 00000108 00000000 00000000 00000000 1 0 0 00000000
1 0 0 0000010c 00000000 00000000 00000000 0 0 0 00000000
1 0 0 00000110 00000000 00000000 00000000 1 0 0 00000000
1 0 0 00000114 00000000 00000000 00000000 0 0 0 00000000
1 0 0 0000011c 00000000 00000000 00000000 1 0 0 00000000
1 0 0 00000124 00000000 00000000 00000000 0 0 0 00000000
1 0 0 00000128 00000000 00000000 00000000 1 0 0 00000000
1 0 0 00000130 00000000 00000000 00000000 1 0 0 00000000
1 0 0 00000134 00000000 00000000 00000000 0 0 0 00000000
1 0 0 00000138 00000000 00000000 00000000 0 0 0 00000000
f 0 0 00000000 00000000 00000000 00000000 0 0 0 00000000

//--- branch_resolve_top.f
+incdir+hdl
hdl/br_pkg.sv
hdl/br_stage_if.sv
hdl/branch_compare.sv
hdl/branch_unit.sv
hdl/branch_history.sv
hdl/branch_resolve_top.sv
sim/branch_resolve_checker.sv
sim/branch_resolve_asserts.sv
sim/branch_resolve_tb.sv

//--- Bender.yml
package:
  name: branch_resolve

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/br_pkg.sv
      - hdl/br_stage_if.sv
      - hdl/branch_compare.sv
      - hdl/branch_unit.sv
      - hdl/branch_history.sv
      - hdl/branch_resolve_top.sv
      - target: simulation
        files:
          - sim/branch_resolve_checker.sv
          - sim/branch_resolve_asserts.sv
          - sim/branch_resolve_tb.sv

//--- sim/branch_resolve_tb.sv
`include "br_defs.svh"

module branch_resolve_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int REC_W      = 11;   // hex words per stim line
    localparam int MAX_REC    = 64;
    localparam int STREAM_CNT = 12;   // first branches run with res_ready_i held high

    logic                clk_i = 1'b0;
    logic                rst_i;
    logic                req_valid_i;
    logic                req_ready_o;
    br_pkg::br_op_e      req_op_i;
    logic                req_pred_taken_i;
    logic [`BR_XLEN-1:0] req_pc_i, req_offset_i, req_rs1_i, req_rs2_i;
    logic                res_valid_o, res_ready_i;
    logic                res_taken_o, res_mispredict_o, res_illegal_o;
    logic [`BR_XLEN-1:0] res_pc_o, res_redirect_pc_o;
    logic [`BR_XLEN-1:0] lkp_pc_i;
    logic                lkp_taken_o;
    logic                exp_taken, exp_mispredict, exp_illegal, lkp_chk, lkp_exp;
    logic [`BR_XLEN-1:0] exp_redirect;
    logic                bp_en;       // random back-pressure on the result side
    logic [31:0]         lfsr;
    logic [31:0]         stim_mem [REC_W*MAX_REC];
    int                  res_errs, lkp_errs, pending, results;
    int                  n_lines, n_branch, tb_errs;

    always #2 clk_i = !clk_i; // 4 ns period

    branch_resolve_top DUT (.*);

    branch_resolve_checker u_checker (
        .clk_i(clk_i), .rst_i(rst_i), .req_valid_i(req_valid_i), .req_ready_i(req_ready_o),
        .exp_taken_i(exp_taken), .exp_mispredict_i(exp_mispredict),
        .exp_illegal_i(exp_illegal), .exp_pc_i(req_pc_i), .exp_redirect_i(exp_redirect),
        .res_valid_i(res_valid_o), .res_ready_i(res_ready_i), .res_taken_i(res_taken_o),
        .res_mispredict_i(res_mispredict_o), .res_illegal_i(res_illegal_o),
        .res_pc_i(res_pc_o), .res_redirect_pc_i(res_redirect_pc_o),
        .lkp_chk_i(lkp_chk), .lkp_exp_i(lkp_exp), .lkp_taken_i(lkp_taken_o),
        .res_errs_o(res_errs), .lkp_errs_o(lkp_errs), .pending_o(pending),
        .results_o(results)
    );

    // fibonacci LFSR with taps 32 22 2 1 whose new bit lands in bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // ready drops when both fresh bits of a cycle are set
    always @(posedge clk_i) begin
        logic b0;
        if (rst_i || !bp_en) begin
            res_ready_i <= 1'b1;
        end else begin
            lfsr = lfsr_next(lfsr);
            b0   = lfsr[0];
            lfsr = lfsr_next(lfsr);
            res_ready_i <= !(b0 && lfsr[0]);
        end
    end

    // holds the request until the DUT takes it
    task automatic send_branch(input int b, input bit stream);
        bp_en            <= !stream;
        req_valid_i      <= 1'b1;
        req_op_i         <= br_pkg::br_op_e'(stim_mem[b+1][2:0]);
        req_pred_taken_i <= stim_mem[b+2][0];
        req_pc_i         <= stim_mem[b+3];
        req_offset_i     <= stim_mem[b+4];
        req_rs1_i        <= stim_mem[b+5];
        req_rs2_i        <= stim_mem[b+6];
        exp_taken        <= stim_mem[b+7][0];
        exp_mispredict   <= stim_mem[b+8][0];
        exp_illegal      <= stim_mem[b+9][0];
        exp_redirect     <= stim_mem[b+10];
        @(posedge clk_i);
        while (!req_ready_o) begin
            if (stream) begin
                $display("request stalled at %0t although results were always taken", $time);
                tb_errs++;
            end
            @(posedge clk_i);
        end
    endtask

    // the checker counts are read between edges and the task returns on a rising edge
    task automatic drain_results();
        req_valid_i <= 1'b0;
        bp_en       <= 1'b0;
        @(negedge clk_i);
        while (pending != 0) @(negedge clk_i);
        @(posedge clk_i);
    endtask

    initial begin
        rst_i            = 1'b1;
        req_valid_i      = 1'b0;
        req_op_i         = br_pkg::BEQ;
        req_pred_taken_i = 1'b0;
        req_pc_i         = '0;
        req_offset_i     = '0;
        req_rs1_i        = '0;
        req_rs2_i        = '0;
        res_ready_i      = 1'b1;
        lkp_pc_i         = '0;
        lkp_chk          = 1'b0;
        lkp_exp          = 1'b0;
        bp_en            = 1'b0;
        exp_taken        = 1'b0;
        exp_mispredict   = 1'b0;
        exp_illegal      = 1'b0;
        exp_redirect     = '0;
        lfsr             = 32'he2d90c8a;
        n_branch         = 0;
        tb_errs          = 0;
        n_lines          = 0;
        $readmemh("sim/branch_resolve_stim.txt", stim_mem);
        while (n_lines < MAX_REC && stim_mem[n_lines*REC_W] !== 32'hf) n_lines++;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);
        for (int i = 0; i < n_lines; i++) begin
            if (stim_mem[i*REC_W] == 32'h0) begin
                send_branch(i*REC_W, n_branch < STREAM_CNT);
                n_branch++;
            end else begin
                if (req_valid_i) drain_results(); // table settles before lookups
                lkp_pc_i <= stim_mem[i*REC_W+3];
                lkp_exp  <= stim_mem[i*REC_W+7][0];
                lkp_chk  <= 1'b1;
                @(posedge clk_i);
            end
        end
        lkp_chk <= 1'b0;
        drain_results();
        if (results != n_branch) begin
            $display("%0d results came back for %0d branches", results, n_branch);
            tb_errs++;
        end
        $display("result errors %0d, lookup errors %0d, other errors %0d",
                 res_errs, lkp_errs, tb_errs);
        if (res_errs + lkp_errs + tb_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // a generous bound per stim line plus the final drain, counted from reset release
    initial begin
        wait (rst_i === 1'b0);
        repeat (n_lines*20 + 200) @(posedge clk_i);
        $display("simulation hung, the DUT stopped answering before the end of the stim");
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- sim/branch_resolve_asserts.sv
`include "br_defs.svh"

// protocol properties of the result port, bound into the top level
module branch_resolve_asserts (
    input logic                clk_i,
    input logic                rst_i,
    input logic                res_valid_o,
    input logic                res_ready_i,
    input logic                res_taken_o,
    input logic                res_mispredict_o,
    input logic                res_illegal_o,
    input logic [`BR_XLEN-1:0] res_pc_o,
    input logic [`BR_XLEN-1:0] res_redirect_pc_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // a stalled result keeps valid and every field until it is taken
    a_hold_stalled : assert property (@(posedge clk_i) disable iff (rst_i)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable({res_taken_o,
        res_mispredict_o, res_illegal_o, res_pc_o, res_redirect_pc_o}))
        else $error("result changed or vanished while stalled");

    a_reset_empty : assert property (@(posedge clk_i) rst_i |=> !res_valid_o)
        else $error("result valid right after reset");

    // an illegal op is never a taken branch nor a misprediction
    a_illegal_quiet : assert property (@(posedge clk_i) disable iff (rst_i)
        res_valid_o && res_illegal_o |-> !res_taken_o && !res_mispredict_o)
        else $error("illegal op reported as taken or mispredicted");

endmodule

bind branch_resolve_top branch_resolve_asserts u_asserts (.*);

//--- sim/branch_resolve_checker.sv
`include "br_defs.svh"

// watches the request and result ports of the branch resolution slice
// expected outcomes ride along with each request and are queued at its handshake
module branch_resolve_checker (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                req_valid_i,
    input  logic                req_ready_i,
    input  logic                exp_taken_i,
    input  logic                exp_mispredict_i,
    input  logic                exp_illegal_i,
    input  logic [`BR_XLEN-1:0] exp_pc_i,
    input  logic [`BR_XLEN-1:0] exp_redirect_i,
    input  logic                res_valid_i,
    input  logic                res_ready_i,
    input  logic                res_taken_i,
    input  logic                res_mispredict_i,
    input  logic                res_illegal_i,
    input  logic [`BR_XLEN-1:0] res_pc_i,
    input  logic [`BR_XLEN-1:0] res_redirect_pc_i,
    input  logic                lkp_chk_i,   // compare the lookup at this edge
    input  logic                lkp_exp_i,
    input  logic                lkp_taken_i,
    output int                  res_errs_o,
    output int                  lkp_errs_o,
    output int                  pending_o,   // results still owed by the DUT
    output int                  results_o    // results seen so far
);

    timeunit 1ns;
    timeprecision 1ps;

    // {taken, mispredict, illegal, pc, redirect}
    logic [2*`BR_XLEN+2:0] exp_q [$];
    logic                  acc_d1;   // request handshake at the previous edge
    logic                  acc_d2;   // request handshake two edges back
    logic                  rdy_d1;   // res_ready_i at the previous edge

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (exp !== got) begin
            $display("FAILED %s exp %h got %h at %0t", name, exp, got, $time);
            res_errs_o++;
        end
    endtask

    initial begin
        res_errs_o = 0;
        lkp_errs_o = 0;
        pending_o  = 0;
        results_o  = 0;
    end

    //////////////////////////////////////////////////////////////////////
    // result side, in request order
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        logic [2*`BR_XLEN+2:0] exp;
        if (!rst_i) begin
            if (req_valid_i && req_ready_i) begin
                exp_q.push_back({exp_taken_i, exp_mispredict_i, exp_illegal_i,
                                 exp_pc_i, exp_redirect_i});
            end
            if (res_valid_i && res_ready_i) begin
                results_o++;
                if (exp_q.size() == 0) begin
                    $display("result at %0t with no request waiting for it", $time);
                    res_errs_o++;
                end else begin
                    exp = exp_q.pop_front();
                    compare_field("res_pc_o", exp[2*`BR_XLEN-1:`BR_XLEN], res_pc_i);
                    compare_field("res_taken_o", exp[2*`BR_XLEN+2], res_taken_i);
                    compare_field("res_mispredict_o", exp[2*`BR_XLEN+1], res_mispredict_i);
                    compare_field("res_illegal_o", exp[2*`BR_XLEN], res_illegal_i);
                    compare_field("res_redirect_pc_o", exp[`BR_XLEN-1:0], res_redirect_pc_i);
                end
            end
            pending_o = exp_q.size();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // two cycle latency while results are taken
    //////////////////////////////////////////////////////////////////////

    // a branch accepted at edge N must be on the result port at edge N+2
    // whenever res_ready_i was high at N+1 and N+2
    always @(posedge clk_i) begin
        if (rst_i) begin
            acc_d1 <= 1'b0;
            acc_d2 <= 1'b0;
            rdy_d1 <= 1'b0;
        end else begin
            if (acc_d2 && rdy_d1 && res_ready_i && !res_valid_i) begin
                $display("result missing two cycles after its request at %0t", $time);
                res_errs_o++;
            end
            acc_d1 <= req_valid_i && req_ready_i;
            acc_d2 <= acc_d1;
            rdy_d1 <= res_ready_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lookup side
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (!rst_i && lkp_chk_i && (lkp_taken_i !== lkp_exp_i)) begin
            $display("FAILED lkp_taken_o exp %h got %h at %0t", lkp_exp_i, lkp_taken_i, $time);
            lkp_errs_o++;
        end
    end

endmodule

//--- hdl/branch_resolve_top.sv
`include "br_defs.svh"

// branch resolution slice
// compare stage, decision stage and history table behind plain ports
// two cycles from request to result, one branch per cycle when not stalled
module branch_resolve_top (
    input  logic                clk_i,
    input  logic                rst_i,
    // request side from decode
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  br_pkg::br_op_e      req_op_i,
    input  logic                req_pred_taken_i,
    input  logic [`BR_XLEN-1:0] req_pc_i,
    input  logic [`BR_XLEN-1:0] req_offset_i,
    input  logic [`BR_XLEN-1:0] req_rs1_i,
    input  logic [`BR_XLEN-1:0] req_rs2_i,
    // result side
    output logic                res_valid_o,
    input  logic                res_ready_i,
    output logic                res_taken_o,
    output logic                res_mispredict_o,
    output logic                res_illegal_o,
    output logic [`BR_XLEN-1:0] res_pc_o,
    output logic [`BR_XLEN-1:0] res_redirect_pc_o,
    // direction lookup for fetch
    input  logic [`BR_XLEN-1:0] lkp_pc_i,
    output logic                lkp_taken_o
);

    logic                upd_valid; // table update, one per legal result
    logic [`BR_XLEN-1:0] upd_pc;
    logic                upd_taken;

    br_stage_if stage_if (); // stage 1 to stage 2

    branch_compare u_compare (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .req_op_i         (req_op_i),
        .req_pred_taken_i (req_pred_taken_i),
        .req_pc_i         (req_pc_i),
        .req_offset_i     (req_offset_i),
        .req_rs1_i        (req_rs1_i),
        .req_rs2_i        (req_rs2_i),
        .out_if           (stage_if.src)
    );

    branch_unit u_unit (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .in_if             (stage_if.dst),
        .res_valid_o       (res_valid_o),
        .res_ready_i       (res_ready_i),
        .res_taken_o       (res_taken_o),
        .res_mispredict_o  (res_mispredict_o),
        .res_illegal_o     (res_illegal_o),
        .res_pc_o          (res_pc_o),
        .res_redirect_pc_o (res_redirect_pc_o),
        .upd_valid_o       (upd_valid),
        .upd_pc_o          (upd_pc),
        .upd_taken_o       (upd_taken)
    );

    branch_history u_history (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .lkp_pc_i    (lkp_pc_i),
        .lkp_taken_o (lkp_taken_o),
        .upd_valid_i (upd_valid),
        .upd_pc_i    (upd_pc),
        .upd_taken_i (upd_taken)
    );

endmodule

//--- hdl/branch_history.sv
`include "br_defs.svh"

// branch history table of 2-bit saturating counters
// indexed by PC bits [BR_BHT_IDX_W+1:2], with no tag, so aliasing PCs share
// a counter
module branch_history (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic [`BR_XLEN-1:0] lkp_pc_i,
    output logic                lkp_taken_o,
    input  logic                upd_valid_i,
    input  logic [`BR_XLEN-1:0] upd_pc_i,
    input  logic                upd_taken_i
);

    br_pkg::ctr_e              ctr_q [`BR_BHT_ENTRIES];
    logic [`BR_BHT_IDX_W-1:0]  lkp_idx;
    logic [`BR_BHT_IDX_W-1:0]  upd_idx;
    br_pkg::ctr_e              lkp_ctr;

    // one step of a saturating counter toward taken or not taken
    function automatic br_pkg::ctr_e ctr_step(input br_pkg::ctr_e cur, input logic taken);
        br_pkg::ctr_e nxt;
        nxt = cur;
        case (cur)
            br_pkg::STRONG_NT: nxt = taken ? br_pkg::WEAK_NT  : br_pkg::STRONG_NT;
            br_pkg::WEAK_NT:   nxt = taken ? br_pkg::WEAK_T   : br_pkg::STRONG_NT;
            br_pkg::WEAK_T:    nxt = taken ? br_pkg::STRONG_T : br_pkg::WEAK_NT;
            br_pkg::STRONG_T:  nxt = taken ? br_pkg::STRONG_T : br_pkg::WEAK_T;
            default:           nxt = br_pkg::WEAK_NT;
        endcase
        return nxt;
    endfunction

    // word aligned PCs, so the two low bits carry no information
    assign lkp_idx = lkp_pc_i[`BR_BHT_IDX_W+1:2];
    assign upd_idx = upd_pc_i[`BR_BHT_IDX_W+1:2];

    //////////////////////////////////////////////////////////////////////
    // counter table
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `BR_BHT_ENTRIES; i++) begin
                ctr_q[i] <= br_pkg::WEAK_NT; // weakly not taken, flips after one taken
            end
        end else if (upd_valid_i) begin
            ctr_q[upd_idx] <= ctr_step(ctr_q[upd_idx], upd_taken_i);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////////////

    // combinational read, sees the table as of the last edge
    assign lkp_ctr     = ctr_q[lkp_idx];
    assign lkp_taken_o = (lkp_ctr == br_pkg::WEAK_T) || (lkp_ctr == br_pkg::STRONG_T);

endmodule

//--- hdl/branch_unit.sv
`include "br_defs.svh"

// stage 2 of branch resolution
// picks the condition by opcode, decides taken and mispredict and works out
// where fetch should have gone, then hands the outcome to the history table
module branch_unit (
    input  logic                clk_i,
    input  logic                rst_i,
    br_stage_if.dst             in_if,
    output logic                res_valid_o,
    input  logic                res_ready_i,
    output logic                res_taken_o,
    output logic                res_mispredict_o,
    output logic                res_illegal_o,
    output logic [`BR_XLEN-1:0] res_pc_o,
    output logic [`BR_XLEN-1:0] res_redirect_pc_o,
    output logic                upd_valid_o,
    output logic [`BR_XLEN-1:0] upd_pc_o,
    output logic                upd_taken_o
);

    logic                res_valid_q;
    logic                taken_q;
    logic                mispredict_q;
    logic                illegal_q;
    logic [`BR_XLEN-1:0] pc_q;
    logic [`BR_XLEN-1:0] redirect_q;
    logic                xfer;          // interface transfer in this cycle
    logic                cond_taken;    // direction from the flags
    logic                op_illegal;    // opcode 6 or 7
    logic [`BR_XLEN-1:0] target_pc;

    //////////////////////////////////////////////////////////////////////
    // condition select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        cond_taken = 1'b0;
        op_illegal = 1'b0;
        case (in_if.payload.op)
            br_pkg::BEQ:  cond_taken = in_if.eq;
            br_pkg::BNE:  cond_taken = !in_if.eq;
            br_pkg::BLT:  cond_taken = in_if.lt;
            br_pkg::BGE:  cond_taken = !in_if.lt;
            br_pkg::BLTU: cond_taken = in_if.ltu;
            br_pkg::BGEU: cond_taken = !in_if.ltu;
            default: begin
                op_illegal = 1'b1; // not a branch, never taken
            end
        endcase
    end

    // pc+offset when taken, otherwise the fall-through instruction
    assign target_pc = cond_taken ? in_if.payload.pc + in_if.payload.offset
                                  : in_if.payload.pc + `BR_XLEN'd4;

    //////////////////////////////////////////////////////////////////////
    // result register
    //////////////////////////////////////////////////////////////////////

    assign in_if.ready = !res_valid_q || res_ready_i; // empty or leaving now
    assign xfer        = in_if.valid && in_if.ready;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            res_valid_q <= 1'b0;
        end else if (in_if.ready) begin
            res_valid_q <= in_if.valid;
        end
    end

    // the outcome only moves on a transfer, so it holds under back-pressure
    always_ff @(posedge clk_i) begin
        if (xfer) begin
            taken_q      <= cond_taken;
            mispredict_q <= !op_illegal && (cond_taken != in_if.payload.pred_taken);
            illegal_q    <= op_illegal;
            pc_q         <= in_if.payload.pc;
            redirect_q   <= target_pc;
        end
    end

    assign res_valid_o       = res_valid_q;
    assign res_taken_o       = taken_q;
    assign res_mispredict_o  = mispredict_q;
    assign res_illegal_o     = illegal_q;
    assign res_pc_o          = pc_q;
    assign res_redirect_pc_o = redirect_q;

    //////////////////////////////////////////////////////////////////////
    // history update
    //////////////////////////////////////////////////////////////////////

    // one pulse per result handshake, illegal ops leave the table alone
    assign upd_valid_o = res_valid_q && res_ready_i && !illegal_q;
    assign upd_pc_o    = pc_q;
    assign upd_taken_o = taken_q;

endmodule

//--- hdl/branch_compare.sv
`include "br_defs.svh"

// stage 1 of branch resolution
// takes a decoded branch, keeps its payload and reduces the two operands
// to the three comparison flags that stage 2 needs
module branch_compare (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  br_pkg::br_op_e      req_op_i,
    input  logic                req_pred_taken_i,
    input  logic [`BR_XLEN-1:0] req_pc_i,
    input  logic [`BR_XLEN-1:0] req_offset_i,
    input  logic [`BR_XLEN-1:0] req_rs1_i,
    input  logic [`BR_XLEN-1:0] req_rs2_i,
    br_stage_if.src             out_if
);

    logic                valid_q;   // the stage register holds a branch
    br_pkg::br_payload_t payload_q;
    logic                eq_q;
    logic                lt_q;
    logic                ltu_q;
    logic                accept;    // request handshake in this cycle

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////

    // free when empty, or when the held branch leaves in the same cycle
    assign req_ready_o = !valid_q || out_if.ready;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (req_ready_o) begin
            valid_q <= req_valid_i; // refill or drain, never drop a held branch
        end
    end

    //////////////////////////////////////////////////////////////////////
    // payload and flags
    //////////////////////////////////////////////////////////////////////

    // loaded only on acceptance so everything stays put while stalled
    always_ff @(posedge clk_i) begin
        if (accept) begin
            payload_q.op         <= req_op_i;
            payload_q.pred_taken <= req_pred_taken_i;
            payload_q.pc         <= req_pc_i;
            payload_q.offset     <= req_offset_i;
            eq_q  <= (req_rs1_i == req_rs2_i);
            lt_q  <= ($signed(req_rs1_i) < $signed(req_rs2_i)); // BLT and BGE
            ltu_q <= (req_rs1_i < req_rs2_i);                   // BLTU and BGEU
        end
    end

    assign out_if.valid   = valid_q;
    assign out_if.payload = payload_q;
    assign out_if.eq      = eq_q;
    assign out_if.lt      = lt_q;
    assign out_if.ltu     = ltu_q;

endmodule

//--- hdl/br_stage_if.sv
// one branch in flight between branch_compare and branch_unit
// a transfer takes place on an edge where valid and ready are both high
interface br_stage_if;

    logic                valid;   // stage 1 holds a branch
    logic                ready;   // stage 2 can take it this cycle
    br_pkg::br_payload_t payload;
    logic                eq;      // rs1 == rs2
    logic                lt;      // signed rs1 < rs2
    logic                ltu;     // unsigned rs1 < rs2

    // producer side, used by the compare stage
    modport src (
        output valid,
        output payload,
        output eq,
        output lt,
        output ltu,
        input  ready
    );

    // consumer side, used by the decision stage
    modport dst (
        input  valid,
        input  payload,
        input  eq,
        input  lt,
        input  ltu,
        output ready
    );

endinterface

//--- hdl/br_pkg.sv
`include "br_defs.svh"

package br_pkg;

    //////////////////////////////////////////////////////////////////////
    // branch opcodes as delivered by decode
    //////////////////////////////////////////////////////////////////////

    // codes 6 and 7 have no name and are resolved as illegal
    typedef enum logic [2:0] {
        BEQ  = 3'd0, // taken when rs1 == rs2
        BNE  = 3'd1, // taken when rs1 != rs2
        BLT  = 3'd2, // signed less than
        BGE  = 3'd3, // signed greater or equal
        BLTU = 3'd4, // unsigned less than
        BGEU = 3'd5  // unsigned greater or equal
    } br_op_e;

    //////////////////////////////////////////////////////////////////////
    // 2-bit saturating counter states of the history table
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        STRONG_NT = 2'd0,
        WEAK_NT   = 2'd1, // reset state of every entry
        WEAK_T    = 2'd2,
        STRONG_T  = 2'd3
    } ctr_e;

    // what travels from the compare stage to the decision stage
    // the operands themselves stop at stage 1, only the flags go on
    typedef struct packed {
        br_op_e              op;
        logic                pred_taken; // direction that fetch guessed
        logic [`BR_XLEN-1:0] pc;
        logic [`BR_XLEN-1:0] offset;     // already sign extended by decode
    } br_payload_t;

endpackage

//--- hdl/br_defs.svh
`ifndef BR_DEFS_SVH
`define BR_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// datapath sizing
//////////////////////////////////////////////////////////////////////

// width of register operands, PCs and branch offsets
`define BR_XLEN 32

//////////////////////////////////////////////////////////////////////
// branch history table sizing
//////////////////////////////////////////////////////////////////////

`define BR_BHT_ENTRIES 16 // one 2-bit counter per entry

// index width, must stay log2 of the entry count
// the index is taken from PC bits [BR_BHT_IDX_W+1:2]
`define BR_BHT_IDX_W 4

`endif
